// ==== include/exec_macros.svh ====
// Execute stage configuration
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Datapath width, RV32 only
`define XLEN 32
`define LOG_XLEN 5            // Shift amount width

// Bit-manipulation extension enables, 1 = built
`define ZBA_SUPPORTED 1       // Address generation
`define ZBB_SUPPORTED 1       // Basic bit manipulation
`define ZBC_SUPPORTED 1       // Carry-less multiply
`define ZBS_SUPPORTED 1       // Single-bit ops

`endif

// ==== src/isaPkg.sv ====
// RV32 instruction encodings
`default_nettype none

package isaPkg;

  // Major opcodes handled by the execute stage
  typedef enum logic [6:0] {
    OP_REG = 7'b0110011,      // Register-register
    OP_IMM = 7'b0010011       // Register-immediate
  } opcodeE;

  // Base funct3 field
  typedef enum logic [2:0] {
    F3_ADD  = 3'd0,           // add, sub, addi
    F3_SLL  = 3'd1,
    F3_SLT  = 3'd2,
    F3_SLTU = 3'd3,
    F3_XOR  = 3'd4,
    F3_SR   = 3'd5,           // srl, sra
    F3_OR   = 3'd6,
    F3_AND  = 3'd7
  } funct3E;

endpackage

`default_nettype wire

// ==== src/aluPkg.sv ====
// ALU control types
`default_nettype none

package aluPkg;

  // Base result select, same order as funct3 except bext
  typedef enum logic [2:0] {
    SEL_SUM, SEL_SHIFT, SEL_SLT, SEL_SLTU,
    SEL_XOR,                  // xor, xnor, binv
    SEL_BEXT,                 // Single bit extract
    SEL_OR,                   // or, orn, bset
    SEL_AND                   // and, andn, bclr
  } aluSelE;

  // Unit that drives the final result
  typedef enum logic [2:0] {
    BSEL_BASE, BSEL_ZBS, BSEL_ZBC, BSEL_ZBB, BSEL_ZBA
  } bSelE;

  // Zbb result select
  typedef enum logic [3:0] {
    ZBB_CLZ, ZBB_CTZ, ZBB_CPOP,
    ZBB_MIN, ZBB_MAX, ZBB_MINU, ZBB_MAXU,
    ZBB_SEXTB, ZBB_SEXTH, ZBB_ZEXTH,
    ZBB_REV8, ZBB_ORCB,
    ZBB_ROT                   // Rotate result from the shifter
  } zbbSelE;

endpackage

`default_nettype wire

// ==== src/aluCtrlIf.sv ====
// Decoded ALU control bundle
`default_nettype none
`include "exec_macros.svh"

interface aluCtrlIf import isaPkg::*, aluPkg::*; ();

  aluSelE           aluSel;   // Base result select
  bSelE             bSel;     // Unit driving the result
  zbbSelE           zbbSel;
  logic             sub;      // Subtract or arithmetic shift
  logic             invB;     // andn, orn, xnor, bclr
  logic             rotate;
  logic [1:0]       shAdd;    // Zba pre-shift of A
  funct3E           funct3;
  logic [`XLEN-1:0] opB;      // rs2 or immediate

  // Decoder side
  modport dec (
    output aluSel, bSel, zbbSel, sub, invB, rotate, shAdd, funct3, opB
  );

  // ALU side
  modport exe (
    input aluSel, bSel, zbbSel, sub, invB, rotate, shAdd, funct3, opB
  );

endinterface

`default_nettype wire

// ==== src/aluDecoder.sv ====
// ALU instruction decoder
`default_nettype none
`include "exec_macros.svh"

module aluDecoder import isaPkg::*, aluPkg::*; (
  input  logic [31:0]      instr,    // Instruction word
  input  logic [`XLEN-1:0] rs2Val,   // Register operand B
  aluCtrlIf.dec            ctrl,     // Controls to the ALU
  output logic             illegal   // Unsupported encoding
);

  localparam bit zbaEn = `ZBA_SUPPORTED;
  localparam bit zbbEn = `ZBB_SUPPORTED;
  localparam bit zbcEn = `ZBC_SUPPORTED;
  localparam bit zbsEn = `ZBS_SUPPORTED;

  opcodeE           op;
  funct3E           f3;
  logic [6:0]       funct7;
  logic [4:0]       rs2f;        // rs2 field, unary op code for Zbb
  logic [`XLEN-1:0] immI;
  logic             isReg;
  logic             isCmp;       // slt(i), sltu(i)
  logic             isLogic;     // xor, or, and funct3

  // Base select from funct3
  function automatic aluSelE baseSel(funct3E f);
    case (f)
      F3_SLL, F3_SR: return SEL_SHIFT;
      F3_SLT:        return SEL_SLT;
      F3_SLTU:       return SEL_SLTU;
      F3_XOR:        return SEL_XOR;
      F3_OR:         return SEL_OR;
      F3_AND:        return SEL_AND;
      default:       return SEL_SUM;
    endcase
  endfunction

  assign op      = opcodeE'(instr[6:0]);
  assign f3      = funct3E'(instr[14:12]);
  assign funct7  = instr[31:25];
  assign rs2f    = instr[24:20];
  assign immI    = {{(`XLEN-12){instr[31]}}, instr[31:20]};   // Sign-extended I-imm
  assign isReg   = (op == OP_REG);
  assign isCmp   = (f3 == F3_SLT) || (f3 == F3_SLTU);
  assign isLogic = (f3 == F3_XOR) || (f3 == F3_OR) || (f3 == F3_AND);

  assign ctrl.funct3 = f3;
  assign ctrl.opB    = isReg ? rs2Val : immI;

  //////////////////////////////////////////////////
  // Control decode

  always_comb begin
    ctrl.aluSel = baseSel(f3);
    ctrl.bSel   = BSEL_BASE;
    ctrl.zbbSel = ZBB_ROT;
    ctrl.sub    = isCmp;       // Compares need A - B
    ctrl.invB   = 1'b0;
    ctrl.rotate = 1'b0;
    ctrl.shAdd  = 2'b00;
    illegal     = 1'b0;
    if (op != OP_REG && op != OP_IMM) begin
      illegal = 1'b1;
    end else if (isReg || f3 == F3_SLL || f3 == F3_SR) begin   // I-type ALU ops keep defaults
      case (funct7)
        7'b0000000: ;                                          // Base encodings
        7'b0100000: begin                                      // sub, sra(i), andn, orn, xnor
          ctrl.sub  = !isLogic;
          ctrl.invB = isLogic;
          if (isLogic) begin
            ctrl.bSel   = BSEL_ZBB;
            ctrl.zbbSel = zbbSelE'(4'hf);                      // Spare code picks logic result
          end
          illegal = isLogic ? !(isReg && zbbEn) : !(f3 == F3_SR || (isReg && f3 == F3_ADD));
        end
        7'b0010000: begin                                      // sh1add, sh2add, sh3add
          ctrl.aluSel = SEL_SUM;
          ctrl.sub    = 1'b0;
          ctrl.bSel   = BSEL_ZBA;
          ctrl.shAdd  = instr[14:13];
          illegal     = !(isReg && zbaEn && !instr[12] && instr[14:13] != 2'b00);
        end
        7'b0000101: begin                                      // clmul*, min/max
          ctrl.sub  = 1'b1;                                    // Flags for min/max
          ctrl.bSel = instr[14] ? BSEL_ZBB : BSEL_ZBC;
          case (f3)
            F3_XOR:  ctrl.zbbSel = ZBB_MIN;
            F3_SR:   ctrl.zbbSel = ZBB_MINU;
            F3_OR:   ctrl.zbbSel = ZBB_MAX;
            default: ctrl.zbbSel = ZBB_MAXU;
          endcase
          illegal = instr[14] ? !(isReg && zbbEn) : !(isReg && zbcEn && f3 != F3_ADD);
        end
        7'b0010100, 7'b0110100: begin                          // bset(i), binv(i), orc.b, rev8
          ctrl.bSel   = (f3 == F3_SR) ? BSEL_ZBB : BSEL_ZBS;
          ctrl.aluSel = funct7[5] ? SEL_XOR : SEL_OR;
          ctrl.zbbSel = funct7[5] ? ZBB_REV8 : ZBB_ORCB;
          if (f3 == F3_SR)
            illegal = !(!isReg && zbbEn && rs2f == (funct7[5] ? 5'b11000 : 5'b00111));
          else
            illegal = !(f3 == F3_SLL && zbsEn);
        end
        7'b0100100: begin                                      // bclr(i), bext(i)
          ctrl.bSel   = BSEL_ZBS;
          ctrl.aluSel = (f3 == F3_SR) ? SEL_BEXT : SEL_AND;
          ctrl.invB   = (f3 == F3_SLL);
          illegal     = !(zbsEn && (f3 == F3_SLL || f3 == F3_SR));
        end
        7'b0110000: begin                                      // rol, ror(i), unary Zbb
          ctrl.bSel = BSEL_ZBB;
          illegal   = !zbbEn || !(f3 == F3_SLL || f3 == F3_SR);
          if (isReg || f3 == F3_SR) begin
            ctrl.aluSel = SEL_SHIFT;
            ctrl.rotate = 1'b1;
          end else begin
            case (rs2f)
              5'd0:    ctrl.zbbSel = ZBB_CLZ;
              5'd1:    ctrl.zbbSel = ZBB_CTZ;
              5'd2:    ctrl.zbbSel = ZBB_CPOP;
              5'd4:    ctrl.zbbSel = ZBB_SEXTB;
              5'd5:    ctrl.zbbSel = ZBB_SEXTH;
              default: illegal = 1'b1;
            endcase
          end
        end
        7'b0000100: begin                                      // zext.h
          ctrl.bSel   = BSEL_ZBB;
          ctrl.zbbSel = ZBB_ZEXTH;
          illegal     = !(isReg && zbbEn && f3 == F3_XOR && rs2f == 5'd0);
        end
        default: illegal = 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/shifter.sv ====
// Barrel shifter with rotate
`default_nettype none
`include "exec_macros.svh"

module shifter (
  input  logic [`XLEN-1:0]     a,
  input  logic [`LOG_XLEN-1:0] amt,      // Shift amount
  input  logic                 right,    // Shift direction
  input  logic                 arith,    // Sign fill on right shift
  input  logic                 rotate,
  output logic [`XLEN-1:0]     y
);

  logic [`XLEN-1:0]   fill;    // Bits shifted in from beyond A
  logic [2*`XLEN-1:0] wide;

  // Fill source
  always_comb begin
    if (rotate)
      fill = a;                            // Wrap around
    else if (right && arith)
      fill = {`XLEN{a[`XLEN-1]}};          // Sign bits
    else
      fill = '0;
  end

  // Double-width shift, keep the word next to the fill
  always_comb begin
    if (right) begin
      wide = {fill, a} >> amt;
      y    = wide[`XLEN-1:0];
    end else begin
      wide = {a, fill} << amt;
      y    = wide[2*`XLEN-1:`XLEN];
    end
  end

endmodule

`default_nettype wire

// ==== src/bitManip.sv ====
// Zbb result unit
`default_nettype none
`include "exec_macros.svh"

module bitManip import aluPkg::*; (
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  input  logic             lt,        // Signed A < B from the ALU
  input  logic             ltu,       // Unsigned A < B
  input  zbbSelE           zbbSel,
  input  logic [`XLEN-1:0] rotY,      // rol/ror result
  input  logic [`XLEN-1:0] logicY,    // andn/orn/xnor result
  output logic [`XLEN-1:0] y
);

  logic [`LOG_XLEN:0] lzCount, tzCount, popCount;
  logic [`XLEN-1:0]   rev8Y, orcbY;

  //////////////////////////////////////////////////
  // Counts

  always_comb begin
    lzCount  = (`LOG_XLEN+1)'(`XLEN);      // All zero gives XLEN
    tzCount  = (`LOG_XLEN+1)'(`XLEN);
    popCount = '0;
    for (int i = 0; i < `XLEN; i++) begin
      if (a[i])           lzCount = (`LOG_XLEN+1)'(`XLEN - 1 - i);   // Highest set bit wins
      if (a[`XLEN-1-i])   tzCount = (`LOG_XLEN+1)'(`XLEN - 1 - i);   // Lowest set bit wins
      popCount = popCount + (`LOG_XLEN+1)'(a[i]);
    end
  end

  // Per-byte ops
  always_comb begin
    for (int i = 0; i < `XLEN/8; i++) begin
      rev8Y[8*i +: 8] = a[`XLEN-8-8*i +: 8];
      orcbY[8*i +: 8] = {8{|a[8*i +: 8]}};
    end
  end

  //////////////////////////////////////////////////
  // Result select

  always_comb begin
    case (zbbSel)
      ZBB_CLZ:   y = {{(`XLEN-`LOG_XLEN-1){1'b0}}, lzCount};
      ZBB_CTZ:   y = {{(`XLEN-`LOG_XLEN-1){1'b0}}, tzCount};
      ZBB_CPOP:  y = {{(`XLEN-`LOG_XLEN-1){1'b0}}, popCount};
      ZBB_MIN:   y = lt  ? a : b;
      ZBB_MAX:   y = lt  ? b : a;
      ZBB_MINU:  y = ltu ? a : b;
      ZBB_MAXU:  y = ltu ? b : a;
      ZBB_SEXTB: y = {{(`XLEN-8){a[7]}}, a[7:0]};
      ZBB_SEXTH: y = {{(`XLEN-16){a[15]}}, a[15:0]};
      ZBB_ZEXTH: y = {{(`XLEN-16){1'b0}}, a[15:0]};
      ZBB_REV8:  y = rev8Y;
      ZBB_ORCB:  y = orcbY;
      ZBB_ROT:   y = rotY;
      default:   y = logicY;               // Inverted logic ops
    endcase
  end

endmodule

`default_nettype wire

// ==== src/carrylessMul.sv ====
// Zbc carry-less multiplier
`default_nettype none
`include "exec_macros.svh"

module carrylessMul import isaPkg::*; (
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  input  funct3E           funct3,   // Picks the product slice
  output logic [`XLEN-1:0] y
);

  logic [2*`XLEN-1:0] prod;    // Full carry-less product

  // XOR of shifted partial products
  always_comb begin
    prod = '0;
    for (int i = 0; i < `XLEN; i++)
      if (b[i]) prod = prod ^ ({{`XLEN{1'b0}}, a} << i);
  end

  always_comb begin
    case (funct3)
      F3_SLT:  y = prod[2*`XLEN-2:`XLEN-1];   // clmulr
      F3_SLTU: y = prod[2*`XLEN-1:`XLEN];     // clmulh
      default: y = prod[`XLEN-1:0];           // clmul
    endcase
  end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
// Integer ALU with bit manipulation
`default_nettype none
`include "exec_macros.svh"

module alu import isaPkg::*, aluPkg::*; (
  input  logic [`XLEN-1:0] a,       // rs1
  aluCtrlIf.exe            ctrl,    // Decoded controls, operand B
  output logic [`XLEN-1:0] y
);

  logic [`XLEN-1:0] b, condMaskB, condInvB, condShiftA;
  logic [`XLEN-1:0] sum, shiftY, baseY, zbcY, zbbY;
  logic             carry, lt, ltu;

  assign b = ctrl.opB;

  //////////////////////////////////////////////////
  // Operand conditioning

  if (`ZBS_SUPPORTED) begin : gZbsMask
    logic [`XLEN-1:0] maskB;                                   // One-hot from B[4:0]
    assign maskB     = {{(`XLEN-1){1'b0}}, 1'b1} << b[`LOG_XLEN-1:0];
    assign condMaskB = (ctrl.bSel == BSEL_ZBS) ? maskB : b;
  end else begin : gNoZbsMask
    assign condMaskB = b;
  end

  if (`ZBA_SUPPORTED) begin : gZbaShift
    assign condShiftA = a << ctrl.shAdd;                       // sh1add..sh3add
  end else begin : gNoZbaShift
    assign condShiftA = a;
  end

  assign condInvB     = (ctrl.sub || ctrl.invB) ? ~condMaskB : condMaskB;
  assign {carry, sum} = condShiftA + condInvB + {{(`XLEN-1){1'b0}}, ctrl.sub};

  // Flags from A - B
  assign lt  = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : sum[`XLEN-1];
  assign ltu = ~carry;                                         // Borrow out

  shifter sh0 (
    .a(a), .amt(b[`LOG_XLEN-1:0]), .right(ctrl.funct3 == F3_SR),
    .arith(ctrl.sub), .rotate(ctrl.rotate), .y(shiftY)
  );

  // Base result
  always_comb begin
    case (ctrl.aluSel)
      SEL_SUM:   baseY = sum;                                  // add, sub, shNadd
      SEL_SHIFT: baseY = shiftY;
      SEL_SLT:   baseY = {{(`XLEN-1){1'b0}}, lt};
      SEL_SLTU:  baseY = {{(`XLEN-1){1'b0}}, ltu};
      SEL_XOR:   baseY = a ^ condInvB;
      SEL_BEXT:  baseY = {{(`XLEN-1){1'b0}}, |(a & condMaskB)};
      SEL_OR:    baseY = a | condInvB;
      default:   baseY = a & condInvB;
    endcase
  end

  //////////////////////////////////////////////////
  // Extension units

  if (`ZBC_SUPPORTED) begin : gZbc
    carrylessMul clmul0 (.a(a), .b(b), .funct3(ctrl.funct3), .y(zbcY));
  end else begin : gNoZbc
    assign zbcY = '0;
  end

  if (`ZBB_SUPPORTED) begin : gZbb
    bitManip bm0 (
      .a(a), .b(b), .lt(lt), .ltu(ltu), .zbbSel(ctrl.zbbSel),
      .rotY(shiftY), .logicY(baseY), .y(zbbY)
    );
  end else begin : gNoZbb
    assign zbbY = '0;
  end

  // Final unit select
  always_comb begin
    case (ctrl.bSel)
      BSEL_ZBC: y = zbcY;
      BSEL_ZBB: y = zbbY;
      default:  y = baseY;                                     // Base, Zba, Zbs
    endcase
  end

endmodule

`default_nettype wire

// ==== src/execUnit.sv ====
// Integer execute stage
`default_nettype none
`include "exec_macros.svh"

module execUnit (
  input  logic             clk,
  input  logic             rstN,
  input  logic             valid,        // Instruction strobe
  input  logic [31:0]      instr,
  input  logic [`XLEN-1:0] rs1Val,
  input  logic [`XLEN-1:0] rs2Val,
  output logic             resultValid,  // One cycle after valid
  output logic [`XLEN-1:0] result,
  output logic             illegal
);

  aluCtrlIf         ctrlIf ();
  logic [`XLEN-1:0] aluY;
  logic             decIllegal;

  aluDecoder dec0 (
    .instr(instr), .rs2Val(rs2Val), .ctrl(ctrlIf.dec), .illegal(decIllegal)
  );

  alu alu0 (.a(rs1Val), .ctrl(ctrlIf.exe), .y(aluY));

  //////////////////////////////////////////////////
  // Result register

  always_ff @(posedge clk) begin
    if (!rstN) begin
      resultValid <= 1'b0;
      result      <= '0;
      illegal     <= 1'b0;
    end else begin
      resultValid <= valid;                          // Single-cycle pulse per accept
      if (valid) begin
        result  <= decIllegal ? '0 : aluY;           // Zero on bad encoding
        illegal <= decIllegal;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/execUnitTb.sv ====
// Execute stage testbench
`default_nettype none
`include "exec_macros.svh"

module execUnitTb import isaPkg::*, aluPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int reps          = 3;                      // Random repeats per op
  localparam int numInstr      = 180;                    // Instructions over all tests
  localparam int timeoutCycles = 40 * numInstr + 100;

  logic             clk;
  logic             rstN;
  logic             valid;
  logic [31:0]      instr;
  logic [`XLEN-1:0] rs1Val;
  logic [`XLEN-1:0] rs2Val;
  logic             resultValid;
  logic [`XLEN-1:0] result;
  logic             illegal;

  int errors = 0;
  int checks = 0;
  int cycles;

  execUnit dut0 (
    .clk(clk), .rstN(rstN), .valid(valid), .instr(instr), .rs1Val(rs1Val),
    .rs2Val(rs2Val), .resultValid(resultValid), .result(result), .illegal(illegal)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  //////////////////////////////////////////////////
  // Instruction encoding

  function automatic logic [31:0] encode(input string op, input logic [11:0] imm);
    logic [16:0] cfg;        // Form, funct7, funct3, rs2 field
    logic [1:0]  kind;       // 0 R, 1 I, 2 shamt imm, 3 unary imm
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rs2f;
    logic [11:0] immF;
    opcodeE      opc;
    case (op)
      "add":    cfg = {2'd0, 7'h00, 3'd0, 5'd2};
      "sub":    cfg = {2'd0, 7'h20, 3'd0, 5'd2};
      "sll":    cfg = {2'd0, 7'h00, 3'd1, 5'd2};
      "slt":    cfg = {2'd0, 7'h00, 3'd2, 5'd2};
      "sltu":   cfg = {2'd0, 7'h00, 3'd3, 5'd2};
      "xor":    cfg = {2'd0, 7'h00, 3'd4, 5'd2};
      "srl":    cfg = {2'd0, 7'h00, 3'd5, 5'd2};
      "sra":    cfg = {2'd0, 7'h20, 3'd5, 5'd2};
      "or":     cfg = {2'd0, 7'h00, 3'd6, 5'd2};
      "and":    cfg = {2'd0, 7'h00, 3'd7, 5'd2};
      "addi":   cfg = {2'd1, 7'h00, 3'd0, 5'd0};
      "slti":   cfg = {2'd1, 7'h00, 3'd2, 5'd0};
      "sltiu":  cfg = {2'd1, 7'h00, 3'd3, 5'd0};
      "xori":   cfg = {2'd1, 7'h00, 3'd4, 5'd0};
      "ori":    cfg = {2'd1, 7'h00, 3'd6, 5'd0};
      "andi":   cfg = {2'd1, 7'h00, 3'd7, 5'd0};
      "slli":   cfg = {2'd2, 7'h00, 3'd1, 5'd0};
      "srli":   cfg = {2'd2, 7'h00, 3'd5, 5'd0};
      "srai":   cfg = {2'd2, 7'h20, 3'd5, 5'd0};
      "sh1add": cfg = {2'd0, 7'h10, 3'd2, 5'd2};   // Zba
      "sh2add": cfg = {2'd0, 7'h10, 3'd4, 5'd2};
      "sh3add": cfg = {2'd0, 7'h10, 3'd6, 5'd2};
      "bset":   cfg = {2'd0, 7'h14, 3'd1, 5'd2};   // Zbs
      "bclr":   cfg = {2'd0, 7'h24, 3'd1, 5'd2};
      "binv":   cfg = {2'd0, 7'h34, 3'd1, 5'd2};
      "bext":   cfg = {2'd0, 7'h24, 3'd5, 5'd2};
      "bseti":  cfg = {2'd2, 7'h14, 3'd1, 5'd0};
      "bclri":  cfg = {2'd2, 7'h24, 3'd1, 5'd0};
      "binvi":  cfg = {2'd2, 7'h34, 3'd1, 5'd0};
      "bexti":  cfg = {2'd2, 7'h24, 3'd5, 5'd0};
      "andn":   cfg = {2'd0, 7'h20, 3'd7, 5'd2};   // Zbb
      "orn":    cfg = {2'd0, 7'h20, 3'd6, 5'd2};
      "xnor":   cfg = {2'd0, 7'h20, 3'd4, 5'd2};
      "clz":    cfg = {2'd3, 7'h30, 3'd1, 5'd0};
      "ctz":    cfg = {2'd3, 7'h30, 3'd1, 5'd1};
      "cpop":   cfg = {2'd3, 7'h30, 3'd1, 5'd2};
      "sext.b": cfg = {2'd3, 7'h30, 3'd1, 5'd4};
      "sext.h": cfg = {2'd3, 7'h30, 3'd1, 5'd5};
      "min":    cfg = {2'd0, 7'h05, 3'd4, 5'd2};
      "minu":   cfg = {2'd0, 7'h05, 3'd5, 5'd2};
      "max":    cfg = {2'd0, 7'h05, 3'd6, 5'd2};
      "maxu":   cfg = {2'd0, 7'h05, 3'd7, 5'd2};
      "zext.h": cfg = {2'd0, 7'h04, 3'd4, 5'd0};
      "rev8":   cfg = {2'd3, 7'h34, 3'd5, 5'd24};
      "orc.b":  cfg = {2'd3, 7'h14, 3'd5, 5'd7};
      "rol":    cfg = {2'd0, 7'h30, 3'd1, 5'd2};
      "ror":    cfg = {2'd0, 7'h30, 3'd5, 5'd2};
      "rori":   cfg = {2'd2, 7'h30, 3'd5, 5'd0};
      "clmul":  cfg = {2'd0, 7'h05, 3'd1, 5'd2};   // Zbc
      "clmulr": cfg = {2'd0, 7'h05, 3'd2, 5'd2};
      "clmulh": cfg = {2'd0, 7'h05, 3'd3, 5'd2};
      default: begin
        cfg = '0;
        $display("Unknown mnemonic %s in encoder", op);
      end
    endcase
    {kind, f7, f3, rs2f} = cfg;
    case (kind)
      2'd1:    immF = imm;
      2'd2:    immF = {f7, imm[4:0]};               // Shift amount form
      default: immF = {f7, rs2f};
    endcase
    opc = (kind == 2'd0) ? OP_REG : OP_IMM;
    return {immF, 5'd1, f3, 5'd3, opc};             // rs1 = x1, rd = x3
  endfunction

  //////////////////////////////////////////////////
  // Reference model from the ISA definitions

  function automatic logic [`XLEN-1:0] expected(input string op,
                                                input logic [`XLEN-1:0] a, b);
    logic [`XLEN-1:0] r;
    logic [4:0]       sh;
    logic             hit;
    sh  = b[4:0];
    r   = '0;
    hit = 1'b0;
    case (op)
      "add", "addi":   r = a + b;
      "sub":           r = a - b;
      "sll", "slli":   r = a << sh;
      "slt", "slti":   r = ($signed(a) < $signed(b)) ? 1 : 0;
      "sltu", "sltiu": r = (a < b) ? 1 : 0;
      "xor", "xori":   r = a ^ b;
      "srl", "srli":   r = a >> sh;
      "sra", "srai":   r = $signed(a) >>> sh;
      "or", "ori":     r = a | b;
      "and", "andi":   r = a & b;
      "sh1add":        r = (a << 1) + b;
      "sh2add":        r = (a << 2) + b;
      "sh3add":        r = (a << 3) + b;
      "bset", "bseti": r = a | (`XLEN'(1) << sh);
      "bclr", "bclri": r = a & ~(`XLEN'(1) << sh);
      "binv", "binvi": r = a ^ (`XLEN'(1) << sh);
      "bext", "bexti": r = `XLEN'(a[sh]);
      "andn":          r = a & ~b;
      "orn":           r = a | ~b;
      "xnor":          r = ~(a ^ b);
      "clz": begin
        for (int i = `XLEN - 1; i >= 0; i--) begin
          if (a[i]) hit = 1'b1;
          else if (!hit) r = r + 1;                 // Zeros above first one
        end
      end
      "ctz": begin
        for (int i = 0; i < `XLEN; i++) begin
          if (a[i]) hit = 1'b1;
          else if (!hit) r = r + 1;
        end
      end
      "cpop":   for (int i = 0; i < `XLEN; i++) r = r + a[i];
      "min":    r = ($signed(a) < $signed(b)) ? a : b;
      "max":    r = ($signed(a) < $signed(b)) ? b : a;
      "minu":   r = (a < b) ? a : b;
      "maxu":   r = (a < b) ? b : a;
      "sext.b": r = $signed(a[7:0]);
      "sext.h": r = $signed(a[15:0]);
      "zext.h": r = a & 32'h0000_ffff;
      "rev8":   r = {a[7:0], a[15:8], a[23:16], a[31:24]};
      "orc.b": begin
        for (int k = 0; k < `XLEN / 8; k++)
          r[8*k +: 8] = (a[8*k +: 8] != 0) ? 8'hff : 8'h00;
      end
      "rol":    r = (a << sh) | (a >> (`XLEN - sh));
      "ror", "rori": r = (a >> sh) | (a << (`XLEN - sh));
      "clmul":  for (int i = 0; i < `XLEN; i++) if (b[i]) r = r ^ (a << i);
      "clmulh": for (int i = 1; i < `XLEN; i++) if (b[i]) r = r ^ (a >> (`XLEN - i));
      "clmulr": for (int i = 0; i < `XLEN; i++) if (b[i]) r = r ^ (a >> (`XLEN - 1 - i));
      default: begin
        r = 'x;
        $display("Unknown mnemonic %s in model", op);
      end
    endcase
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Checks and issue helpers

  task automatic checkResult(input string what, input logic [`XLEN-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s result %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkIllegal(input string what, input logic got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s illegal %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic reportTest(input string name, input int e0);
    $display("Test %-14s %s, %0d errors", name, (errors == e0) ? "ok" : "failed", errors - e0);
  endtask

  // One instruction with valid high for one cycle
  task automatic issueWord(input string what, input logic [31:0] word,
                           input logic [`XLEN-1:0] a, rs2, expY, input logic expIll);
    @(posedge clk);
    valid  <= 1'b1;
    instr  <= word;
    rs1Val <= a;
    rs2Val <= rs2;
    @(posedge clk);
    valid <= 1'b0;
    @(negedge clk);
    if (resultValid !== 1'b1) begin
      errors++;
      $display("No resultValid pulse one cycle after valid for %s", what);
    end else begin
      checkResult(what, result, expY);
      checkIllegal(what, illegal, expIll);
    end
    @(negedge clk);
    if (resultValid !== 1'b0) begin   // Pulse must be one cycle wide
      errors++;
      $display("resultValid stayed high for more than one cycle after %s", what);
    end
  endtask

  task automatic execOp(input string op, input logic [`XLEN-1:0] a, rs2,
                        input logic [11:0] imm);
    logic [31:0]      word;
    logic [`XLEN-1:0] bEff;               // rs2 or sign-extended I-imm
    word = encode(op, imm);
    if (word[6:0] == OP_REG)
      bEff = rs2;
    else
      bEff = $signed(word[31:20]);
    issueWord(op, word, a, rs2, expected(op, a, bEff), 1'b0);
  endtask

  //////////////////////////////////////////////////
  // Tests

  task automatic resetStateTest();
    int e0;
    e0 = errors;
    repeat (2) @(negedge clk);
    if (resultValid !== 1'b0) begin
      errors++;
      $display("[FAIL] %0t: resultValid high after reset", $time);
    end
    checkIllegal("after reset", illegal, 1'b0);
    checkResult("after reset", result, '0);
    reportTest("reset state", e0);
  endtask

  task automatic baseOpsTest();
    string ops [19] = '{"add", "sub", "slt", "sltu", "xor", "or", "and", "sll", "srl",
                        "sra", "addi", "slti", "sltiu", "xori", "ori", "andi", "slli",
                        "srli", "srai"};
    int e0;
    e0 = errors;
    foreach (ops[i])
      repeat (reps) execOp(ops[i], $urandom, $urandom, 12'($urandom));
    reportTest("base ops", e0);
  endtask

  task automatic zbaZbsTest();
    string ops [11] = '{"sh1add", "sh2add", "sh3add", "bset", "bclr", "binv", "bext",
                        "bseti", "bclri", "binvi", "bexti"};
    int e0;
    e0 = errors;
    foreach (ops[i])
      repeat (reps) execOp(ops[i], $urandom, $urandom, 12'($urandom));
    reportTest("zba zbs", e0);
  endtask

  task automatic zbbTest();
    string logicOps [3]  = '{"andn", "orn", "xnor"};
    string countOps [3]  = '{"clz", "ctz", "cpop"};
    string minMaxOps [4] = '{"min", "max", "minu", "maxu"};
    string unaryOps [5]  = '{"sext.b", "sext.h", "zext.h", "rev8", "orc.b"};
    string rotOps [3]    = '{"rol", "ror", "rori"};
    logic [`XLEN-1:0] masks [3] = '{32'hffff_ffff, 32'h00ff_ff00, 32'hff00_00ff};
    logic [`XLEN-1:0] edgeA [4];
    int e0;
    e0 = errors;
    edgeA[0] = '0;                        // Edge operands
    edgeA[1] = '1;
    edgeA[2] = $urandom;
    edgeA[3] = $urandom >> 9;
    foreach (logicOps[i])
      repeat (reps) execOp(logicOps[i], $urandom, $urandom, 12'd0);
    foreach (countOps[i])
      foreach (edgeA[k]) execOp(countOps[i], edgeA[k], $urandom, 12'd0);
    foreach (minMaxOps[i]) begin          // Mixed signs both ways
      execOp(minMaxOps[i], $urandom | 32'h8000_0000, $urandom & 32'h7fff_ffff, 12'd0);
      execOp(minMaxOps[i], $urandom & 32'h7fff_ffff, $urandom | 32'h8000_0000, 12'd0);
      execOp(minMaxOps[i], $urandom, $urandom, 12'd0);
    end
    foreach (unaryOps[i])
      foreach (masks[k]) execOp(unaryOps[i], $urandom & masks[k], $urandom, 12'd0);
    foreach (rotOps[i])
      repeat (reps) execOp(rotOps[i], $urandom, $urandom, 12'($urandom));
    reportTest("zbb", e0);
  endtask

  task automatic zbcTest();
    string ops [3] = '{"clmul", "clmulh", "clmulr"};
    int e0;
    e0 = errors;
    foreach (ops[i]) begin
      repeat (reps) execOp(ops[i], $urandom, $urandom, 12'd0);
      execOp(ops[i], `XLEN'(1) << ($urandom % 32), `XLEN'(1) << ($urandom % 32), 12'd0);
      execOp(ops[i], 32'h8000_0000, 32'h8000_0000, 12'd0);   // Top product bit
    end
    reportTest("zbc", e0);
  endtask

  task automatic backToBackTest();
    string ops [8] = '{"add", "sub", "xor", "min", "clmul", "ror", "sh2add", "bset"};
    logic [`XLEN-1:0] expQ [$];
    string            nameQ [$];
    logic [`XLEN-1:0] a, b, expY;
    string            name;
    int e0;
    e0 = errors;
    for (int k = 0; k <= 16; k++) begin
      @(posedge clk);
      if (k < 16) begin                   // New instruction every cycle
        a = $urandom;
        b = $urandom;
        valid  <= 1'b1;
        instr  <= encode(ops[k % 8], 12'd0);
        rs1Val <= a;
        rs2Val <= b;
        expQ.push_back(expected(ops[k % 8], a, b));
        nameQ.push_back(ops[k % 8]);
      end else begin
        valid <= 1'b0;
      end
      @(negedge clk);
      if (k > 0) begin                    // Result of the previous issue
        expY = expQ.pop_front();
        name = nameQ.pop_front();
        if (resultValid !== 1'b1) begin
          errors++;
          $display("No resultValid in back-to-back issue for %s", name);
        end else begin
          checkResult(name, result, expY);
        end
      end
    end
    issueWord("bad funct7", {7'h7f, 5'd2, 5'd1, 3'd0, 5'd3, OP_REG},
              $urandom, $urandom, '0, 1'b1);
    issueWord("bad opcode", {12'h000, 5'd1, 3'd2, 5'd3, 7'b0000011},
              $urandom, $urandom, '0, 1'b1);
    reportTest("back to back", e0);
  endtask

  //////////////////////////////////////////////////
  // Run control

  initial begin
    void'($urandom(32'hffbb));            // Seed once
    rstN   = 1'b0;
    valid  = 1'b0;
    instr  = '0;
    rs1Val = '0;
    rs2Val = '0;
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    resetStateTest();
    baseOpsTest();
    zbaZbsTest();
    zbbTest();
    zbcTest();
    backToBackTest();
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // Cycle limit
  initial begin
    cycles = 0;
    while (cycles < timeoutCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, tests did not finish", cycles);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
src/isaPkg.sv
src/aluPkg.sv
src/aluCtrlIf.sv
src/aluDecoder.sv
src/shifter.sv
src/bitManip.sv
src/carrylessMul.sv
src/alu.sv
src/execUnit.sv
tests/execUnitTb.sv
